/* files.f */
+incdir+hdl
hdl/ccu_pkg.sv
hdl/ccu_req_decoder.sv
hdl/ccu_ack_queue.sv
hdl/ccu_mem_arbiter.sv
hdl/ccu_resp_router.sv
hdl/ccu_master_path.sv
verification/tb_ccu_master_path.sv

/* hdl/ccu_ack_queue.sv */
`default_nettype none

`include "ccu_cfg.svh"

module ccu_ack_queue (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  logic [`CCU_CM_W-1:0] addr_i,
  output logic                 full_o,
  input  logic                 ack_i,
  output logic                 cm_valid_o,
  output logic [`CCU_CM_W-1:0] cm_addr_o
);

  localparam int unsigned depth = `CCU_ACK_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic [`CCU_CM_W-1:0] mem_q [depth];
  logic [ptr_w-1:0]     wr_ptr_q;
  logic [ptr_w-1:0]     rd_ptr_q;
  logic [cnt_w-1:0]     count_q;
  logic                 pop;

  assign full_o = (count_q == cnt_w'(depth));
  // Ack on an empty queue is dropped
  assign pop    = ack_i && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      cm_valid_o <= 1'b0;
    end else begin
      cm_valid_o <= pop;
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= addr_i;
    end
    if (pop) begin
      cm_addr_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

/* hdl/ccu_cfg.svh */
`ifndef CCU_CFG_SVH
`define CCU_CFG_SVH

// Request ports and port index width
`define CCU_NUM_PORTS 2
`define CCU_PORT_W    1

// Bus widths
`define CCU_ADDR_W    32
`define CCU_DATA_W    32

// Id at a port, tag toward memory
`define CCU_ID_W      3
`define CCU_TAG_W     4

// Coherence monitor address slice
`define CCU_CM_BASE   6
`define CCU_CM_W      8

// Entries per ack queue
`define CCU_ACK_DEPTH 2

`endif

/* hdl/ccu_master_path.sv */
`default_nettype none

`include "ccu_cfg.svh"

module ccu_master_path (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                [`CCU_NUM_PORTS-1:0]  req_valid_i,
  output logic                [`CCU_NUM_PORTS-1:0]  req_ready_o,
  input  ccu_pkg::req_t       [`CCU_NUM_PORTS-1:0]  req_i,
  output logic                [`CCU_NUM_PORTS-1:0]  resp_valid_o,
  input  logic                [`CCU_NUM_PORTS-1:0]  resp_ready_i,
  output ccu_pkg::port_resp_t [`CCU_NUM_PORTS-1:0]  resp_o,
  input  logic                [`CCU_NUM_PORTS-1:0]  ack_i,
  output logic                [`CCU_NUM_PORTS-1:0]  cm_valid_o,
  output logic [`CCU_NUM_PORTS-1:0][`CCU_CM_W-1:0]  cm_addr_o,
  output logic                                      mem_req_valid_o,
  input  logic                                      mem_req_ready_i,
  output ccu_pkg::mem_req_t                         mem_req_o,
  input  logic                                      mem_resp_valid_i,
  output logic                                      mem_resp_ready_o,
  input  ccu_pkg::mem_resp_t                        mem_resp_i
);

  ccu_pkg::req_class_e [`CCU_NUM_PORTS-1:0] req_class;
  logic                                     issue_valid;
  ccu_pkg::issue_t                          issue;
  logic                                     err_valid;
  logic                                     err_ready;
  ccu_pkg::port_resp_t                      err_resp;
  logic [`CCU_PORT_W-1:0]                   err_port;

  ////////////////////
  // Decode
  ////////////////////

  for (genvar p = 0; p < `CCU_NUM_PORTS; p++) begin : gen_decoder
    ccu_req_decoder i_req_decoder (
      .req_i   (req_i[p]),
      .class_o (req_class[p])
    );
  end

  ccu_mem_arbiter i_mem_arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_i           (req_i),
    .class_i         (req_class),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o),
    .issue_valid_o   (issue_valid),
    .issue_o         (issue),
    .err_valid_o     (err_valid),
    .err_ready_i     (err_ready),
    .err_o           (err_resp),
    .err_port_o      (err_port)
  );

  // Responses back to the issuing port
  ccu_resp_router i_resp_router (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .issue_valid_i    (issue_valid),
    .issue_i          (issue),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .mem_resp_i       (mem_resp_i),
    .err_valid_i      (err_valid),
    .err_ready_o      (err_ready),
    .err_i            (err_resp),
    .err_port_i       (err_port),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_o           (resp_o),
    .ack_i            (ack_i),
    .cm_valid_o       (cm_valid_o),
    .cm_addr_o        (cm_addr_o)
  );

endmodule

`default_nettype wire

/* hdl/ccu_mem_arbiter.sv */
`default_nettype none

`include "ccu_cfg.svh"

module ccu_mem_arbiter (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                   [`CCU_NUM_PORTS-1:0]  req_valid_i,
  output logic                   [`CCU_NUM_PORTS-1:0]  req_ready_o,
  input  ccu_pkg::req_t          [`CCU_NUM_PORTS-1:0]  req_i,
  input  ccu_pkg::req_class_e    [`CCU_NUM_PORTS-1:0]  class_i,
  output logic                                         mem_req_valid_o,
  input  logic                                         mem_req_ready_i,
  output ccu_pkg::mem_req_t                            mem_req_o,
  output logic                                         issue_valid_o,
  output ccu_pkg::issue_t                              issue_o,
  output logic                                         err_valid_o,
  input  logic                                         err_ready_i,
  output ccu_pkg::port_resp_t                          err_o,
  output logic                   [`CCU_PORT_W-1:0]     err_port_o
);

  localparam int unsigned num_ports = `CCU_NUM_PORTS;
  localparam int unsigned port_w    = `CCU_PORT_W;

  logic [port_w-1:0]    rr_ptr_q;
  logic [port_w-1:0]    scan_idx;
  logic [port_w-1:0]    grant_idx;
  logic                 grant_found;
  logic [num_ports-1:0] eligible;
  logic                 mem_free;
  logic                 accept;
  logic                 accept_legal;
  logic                 accept_illegal;
  ccu_pkg::req_t        grant_req;
  ccu_pkg::req_class_e  grant_class;

  ////////////////////
  // Selection
  ////////////////////

  // Illegal requests wait while the error slot is occupied
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      eligible[p] = req_valid_i[p] &&
                    ((class_i[p] != ccu_pkg::ClassIllegal) || !err_valid_o);
    end
  end

  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    scan_idx    = '0;
    for (int off = 0; off < num_ports; off++) begin
      scan_idx = port_w'((int'(rr_ptr_q) + off) % num_ports);
      if (!grant_found && eligible[scan_idx]) begin
        grant_found = 1'b1;
        grant_idx   = scan_idx;
      end
    end
  end

  assign grant_req      = req_i[grant_idx];
  assign grant_class    = class_i[grant_idx];
  assign mem_free       = !mem_req_valid_o || mem_req_ready_i;
  assign accept         = grant_found && mem_free;
  assign accept_legal   = accept && (grant_class != ccu_pkg::ClassIllegal);
  assign accept_illegal = accept && (grant_class == ccu_pkg::ClassIllegal);

  always_comb begin
    req_ready_o            = '0;
    req_ready_o[grant_idx] = accept;
  end

  // Issue record for the response router
  assign issue_valid_o   = accept_legal;
  assign issue_o.tag     = {grant_idx, grant_req.id};
  assign issue_o.cm_addr = grant_req.addr[`CCU_CM_BASE +: `CCU_CM_W];
  assign issue_o.snoop   = (grant_class == ccu_pkg::ClassSnoop);

  ////////////////////
  // Output registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q        <= '0;
      mem_req_valid_o <= 1'b0;
      err_valid_o     <= 1'b0;
    end else begin
      if (accept) begin
        rr_ptr_q <= (grant_idx == port_w'(num_ports - 1)) ? '0 : grant_idx + 1'b1;
      end
      if (mem_req_ready_i) begin
        mem_req_valid_o <= 1'b0;
      end
      if (accept_legal) begin
        mem_req_valid_o <= 1'b1;
      end
      if (err_ready_i) begin
        err_valid_o <= 1'b0;
      end
      if (accept_illegal) begin
        err_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_legal) begin
      mem_req_o.write <= grant_req.write;
      mem_req_o.addr  <= grant_req.addr;
      mem_req_o.tag   <= {grant_idx, grant_req.id};
      mem_req_o.op    <= grant_req.op;
      mem_req_o.wdata <= grant_req.wdata;
    end
    if (accept_illegal) begin
      err_o.id    <= grant_req.id;
      err_o.rdata <= '0;
      err_o.err   <= 1'b1;
      err_port_o  <= grant_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/ccu_pkg.sv */
`default_nettype none

`include "ccu_cfg.svh"

package ccu_pkg;

  typedef enum logic [1:0] {
    DomNonShareable = 2'd0,
    DomInner        = 2'd1,
    DomOuter        = 2'd2,
    DomSystem       = 2'd3
  } domain_e;

  // Code 0 is ReadOnce in a shareable domain
  typedef enum logic [3:0] {
    ReadNoSnoop = 4'd0,
    ReadShared  = 4'd1,
    ReadClean   = 4'd2,
    ReadUnique  = 4'd7
  } read_op_e;

  // Code 0 is WriteUnique in a shareable domain
  typedef enum logic [3:0] {
    WriteNoSnoop    = 4'd0,
    WriteLineUnique = 4'd1,
    WriteBack       = 4'd3
  } write_op_e;

  typedef union packed {
    read_op_e  rd;
    write_op_e wr;
  } snoop_op_u;

  typedef struct packed {
    logic                   write;
    logic [`CCU_ADDR_W-1:0] addr;
    logic [`CCU_ID_W-1:0]   id;
    snoop_op_u              op;
    domain_e                domain;
    logic [`CCU_DATA_W-1:0] wdata;
  } req_t;

  typedef enum logic [1:0] {
    ClassNoSnoop = 2'd0,
    ClassSnoop   = 2'd1,
    ClassIllegal = 2'd2
  } req_class_e;

  typedef struct packed {
    logic                   write;
    logic [`CCU_ADDR_W-1:0] addr;
    logic [`CCU_TAG_W-1:0]  tag;
    snoop_op_u              op;
    logic [`CCU_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [`CCU_TAG_W-1:0]  tag;
    logic [`CCU_DATA_W-1:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic [`CCU_ID_W-1:0]   id;
    logic [`CCU_DATA_W-1:0] rdata;
    logic                   err;
  } port_resp_t;

  typedef struct packed {
    logic [`CCU_TAG_W-1:0] tag;
    logic [`CCU_CM_W-1:0]  cm_addr;
    logic                  snoop;
  } issue_t;

endpackage

`default_nettype wire

/* hdl/ccu_req_decoder.sv */
`default_nettype none

module ccu_req_decoder (
  input  ccu_pkg::req_t       req_i,
  output ccu_pkg::req_class_e class_o
);

  logic op_legal;
  logic op_zero;

  // Legal snooping opcodes of each view
  always_comb begin
    op_legal = 1'b0;
    if (req_i.write) begin
      case (req_i.op.wr)
        ccu_pkg::WriteNoSnoop,
        ccu_pkg::WriteLineUnique,
        ccu_pkg::WriteBack: op_legal = 1'b1;
        default:            op_legal = 1'b0;
      endcase
    end else begin
      case (req_i.op.rd)
        ccu_pkg::ReadNoSnoop,
        ccu_pkg::ReadShared,
        ccu_pkg::ReadClean,
        ccu_pkg::ReadUnique: op_legal = 1'b1;
        default:             op_legal = 1'b0;
      endcase
    end
  end

  // Plain opcode is code 0 in both views
  assign op_zero = (req_i.op == '0);

  always_comb begin
    case (req_i.domain)
      ccu_pkg::DomInner,
      ccu_pkg::DomOuter: begin
        class_o = op_legal ? ccu_pkg::ClassSnoop : ccu_pkg::ClassIllegal;
      end
      // Non-shareable and system only take the plain opcode
      default: begin
        class_o = op_zero ? ccu_pkg::ClassNoSnoop : ccu_pkg::ClassIllegal;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ccu_resp_router.sv */
`default_nettype none

`include "ccu_cfg.svh"

module ccu_resp_router (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        issue_valid_i,
  input  ccu_pkg::issue_t                             issue_i,
  input  logic                                        mem_resp_valid_i,
  output logic                                        mem_resp_ready_o,
  input  ccu_pkg::mem_resp_t                          mem_resp_i,
  input  logic                                        err_valid_i,
  output logic                                        err_ready_o,
  input  ccu_pkg::port_resp_t                         err_i,
  input  logic                [`CCU_PORT_W-1:0]       err_port_i,
  output logic                [`CCU_NUM_PORTS-1:0]    resp_valid_o,
  input  logic                [`CCU_NUM_PORTS-1:0]    resp_ready_i,
  output ccu_pkg::port_resp_t [`CCU_NUM_PORTS-1:0]    resp_o,
  input  logic                [`CCU_NUM_PORTS-1:0]    ack_i,
  output logic                [`CCU_NUM_PORTS-1:0]    cm_valid_o,
  output logic [`CCU_NUM_PORTS-1:0][`CCU_CM_W-1:0]    cm_addr_o
);

  logic [`CCU_CM_W-1:0]      cm_tab [2**`CCU_TAG_W];
  logic                      snoop_tab [2**`CCU_TAG_W];
  logic [`CCU_PORT_W-1:0]    mem_port;
  logic                      mem_snoop;
  logic [`CCU_CM_W-1:0]      mem_cm;
  logic                      mem_sel;
  logic [`CCU_NUM_PORTS-1:0] q_full;
  logic [`CCU_NUM_PORTS-1:0] q_push;
  ccu_pkg::port_resp_t       out_resp;

  // Per tag slice and snoop flag of issued transactions
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      cm_tab[issue_i.tag]    <= issue_i.cm_addr;
      snoop_tab[issue_i.tag] <= issue_i.snoop;
    end
  end

  assign mem_port  = mem_resp_i.tag[`CCU_TAG_W-1 -: `CCU_PORT_W];
  assign mem_snoop = snoop_tab[mem_resp_i.tag];
  assign mem_cm    = cm_tab[mem_resp_i.tag];

  // Memory wins unless its snoop queue is full
  assign mem_sel = mem_resp_valid_i && !(mem_snoop && q_full[mem_port]);

  assign out_resp.id    = mem_sel ? mem_resp_i.tag[`CCU_ID_W-1:0] : err_i.id;
  assign out_resp.rdata = mem_sel ? mem_resp_i.rdata : err_i.rdata;
  assign out_resp.err   = mem_sel ? 1'b0 : err_i.err;

  always_comb begin
    resp_valid_o = '0;
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      resp_o[p] = out_resp;
    end
    if (mem_sel) begin
      resp_valid_o[mem_port] = 1'b1;
    end else if (err_valid_i) begin
      resp_valid_o[err_port_i] = 1'b1;
    end
  end

  assign mem_resp_ready_o = mem_sel && resp_ready_i[mem_port];
  assign err_ready_o      = !mem_sel && resp_ready_i[err_port_i];

  ////////////////////
  // Ack queues
  ////////////////////

  for (genvar p = 0; p < `CCU_NUM_PORTS; p++) begin : gen_ack_queue
    assign q_push[p] = mem_resp_ready_o && mem_resp_valid_i && mem_snoop &&
                       (mem_port == p);

    ccu_ack_queue i_ack_queue (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (q_push[p]),
      .addr_i     (mem_cm),
      .full_o     (q_full[p]),
      .ack_i      (ack_i[p]),
      .cm_valid_o (cm_valid_o[p]),
      .cm_addr_o  (cm_addr_o[p])
    );
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the master path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_ccu_master_path \
  -o tb_ccu_master_path
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_ccu_master_path
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

echo "Simulation ended with status 0"
exit 0

/* verification/tb_ccu_master_path.sv */
`default_nettype none

`include "ccu_cfg.svh"

module tb_ccu_master_path;

  localparam int unsigned num_txn     = 400;
  localparam int unsigned max_cycles  = 100000;
  localparam int unsigned num_tags    = 2**`CCU_TAG_W;
  localparam logic [1:0]  cls_plain   = 2'd0;
  localparam logic [1:0]  cls_snoop   = 2'd1;
  localparam logic [1:0]  cls_illegal = 2'd2;

  logic                                     clk;
  logic                                     reset;
  logic                [`CCU_NUM_PORTS-1:0] req_valid;
  logic                [`CCU_NUM_PORTS-1:0] req_ready;
  ccu_pkg::req_t       [`CCU_NUM_PORTS-1:0] req;
  logic                [`CCU_NUM_PORTS-1:0] resp_valid;
  logic                [`CCU_NUM_PORTS-1:0] resp_ready;
  ccu_pkg::port_resp_t [`CCU_NUM_PORTS-1:0] resp;
  logic                [`CCU_NUM_PORTS-1:0] ack;
  logic                [`CCU_NUM_PORTS-1:0] cm_valid;
  logic [`CCU_NUM_PORTS-1:0][`CCU_CM_W-1:0] cm_addr;
  logic                                     mem_req_valid;
  logic                                     mem_req_ready;
  ccu_pkg::mem_req_t                        mem_req;
  logic                                     mem_resp_valid;
  logic                                     mem_resp_ready;
  ccu_pkg::mem_resp_t                       mem_resp;

  logic [31:0]            lfsr_state;
  // Reference record per tag {port, id}
  logic                   rec_busy     [num_tags];
  logic                   rec_accepted [num_tags];
  logic                   rec_at_mem   [num_tags];
  logic                   rec_write    [num_tags];
  logic [`CCU_ADDR_W-1:0] rec_addr     [num_tags];
  logic [3:0]             rec_op       [num_tags];
  logic [`CCU_DATA_W-1:0] rec_wdata    [num_tags];
  logic [1:0]             rec_class    [num_tags];
  logic [`CCU_TAG_W-1:0]  req_tag      [`CCU_NUM_PORTS];
  logic                   req_taken    [`CCU_NUM_PORTS];
  // Memory model
  logic [`CCU_TAG_W-1:0]  mem_pend [$];
  logic [`CCU_ADDR_W-1:0] mem_addr     [num_tags];
  logic                   mem_write    [num_tags];
  logic                   mem_resp_done;
  // Ack queue model and expected pulses
  logic [`CCU_CM_W-1:0]   cm_model   [`CCU_NUM_PORTS][$];
  logic                   pulse_due  [`CCU_NUM_PORTS];
  logic [`CCU_CM_W-1:0]   pulse_addr [`CCU_NUM_PORTS];
  int unsigned            issued;
  int unsigned            done_count;
  int unsigned            cycle;
  logic                   finished;

  ccu_master_path i_dut (
    .clk_i            (clk),
    .reset_i          (reset),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_i            (req),
    .resp_valid_o     (resp_valid),
    .resp_ready_i     (resp_ready),
    .resp_o           (resp),
    .ack_i            (ack),
    .cm_valid_o       (cm_valid),
    .cm_addr_o        (cm_addr),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_o        (mem_req),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_ready_o (mem_resp_ready),
    .mem_resp_i       (mem_resp)
  );

  always #10 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic logic [1:0] expected_class(input logic write, input logic [3:0] op,
                                                input logic [1:0] domain);
    logic legal;
    if (write) begin
      legal = (op == 4'd0) || (op == 4'd1) || (op == 4'd3);
    end else begin
      legal = (op == 4'd0) || (op == 4'd1) || (op == 4'd2) || (op == 4'd7);
    end
    // Inner and outer domains snoop
    if (domain == 2'd1 || domain == 2'd2) begin
      return legal ? cls_snoop : cls_illegal;
    end
    return (op == 4'd0) ? cls_plain : cls_illegal;
  endfunction

  function automatic logic [3:0] pick_opcode(input logic write);
    logic [1:0] sel;
    logic [3:0] op;
    sel = 2'(rand_bits(2));
    if (rand_bits(2) == '0) begin
      op = 4'(rand_bits(4));
    end else if (write) begin
      case (sel)
        2'd0:    op = 4'd0;
        2'd1:    op = 4'd1;
        default: op = 4'd3;
      endcase
    end else begin
      case (sel)
        2'd0:    op = 4'd0;
        2'd1:    op = 4'd1;
        2'd2:    op = 4'd2;
        default: op = 4'd7;
      endcase
    end
    return op;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_idle_outputs(input string name);
    assert ({req_ready, resp_valid, mem_req_valid, mem_resp_ready, cm_valid} == '0)
      else report_mismatch(name, 64'd0,
                           64'({req_ready, resp_valid, mem_req_valid, mem_resp_ready, cm_valid}));
  endtask

  task automatic new_request(input int p, input logic [`CCU_TAG_W-1:0] tag);
    logic       write;
    logic [3:0] op;
    logic [1:0] dom;
    write          = rand_bits(1) != '0;
    op             = pick_opcode(write);
    dom            = 2'(rand_bits(2));
    req[p].write   = write;
    req[p].addr    = rand_bits(32);
    req[p].id      = tag[`CCU_ID_W-1:0];
    req[p].op      = op;
    req[p].domain  = ccu_pkg::domain_e'(dom);
    req[p].wdata   = rand_bits(32);
    req_valid[p]   = 1'b1;
    rec_busy[tag]  = 1'b1;
    rec_write[tag] = write;
    rec_addr[tag]  = req[p].addr;
    rec_op[tag]    = op;
    rec_wdata[tag] = req[p].wdata;
    rec_class[tag] = expected_class(write, op, dom);
    issued++;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_inputs();
    logic [`CCU_ID_W-1:0]  start_id;
    logic [`CCU_ID_W-1:0]  cand;
    logic [`CCU_TAG_W-1:0] tag;
    logic                  found;
    int unsigned           idx;
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      if (req_taken[p]) begin
        req_valid[p] = 1'b0;
        req_taken[p] = 1'b0;
      end
      if (!req_valid[p] && issued < num_txn && rand_bits(1) != '0) begin
        // Free id search so ids are never reused while outstanding
        start_id = `CCU_ID_W'(rand_bits(`CCU_ID_W));
        found    = 1'b0;
        for (int k = 0; k < 2**`CCU_ID_W; k++) begin
          cand = start_id + `CCU_ID_W'(k);
          tag  = {`CCU_PORT_W'(p), cand};
          if (!found && !rec_busy[tag]) begin
            found      = 1'b1;
            req_tag[p] = tag;
          end
        end
        if (found) begin
          new_request(p, req_tag[p]);
        end
      end
      resp_ready[p] = rand_bits(2) != '0;
      ack[p]        = rand_bits(3) == '0;
    end
    mem_req_ready = rand_bits(2) != '0;
    if (mem_resp_done) begin
      mem_resp_valid = 1'b0;
      mem_resp_done  = 1'b0;
    end
    // Memory returns a random pending request
    if (!mem_resp_valid && mem_pend.size() != 0 && rand_bits(1) != '0) begin
      idx = rand_bits(8) % mem_pend.size();
      tag = mem_pend[idx];
      mem_pend.delete(idx);
      mem_resp.tag   = tag;
      mem_resp.rdata = mem_write[tag] ? '0 : (mem_addr[tag] ^ 32'h5a5a5a5a);
      mem_resp_valid = 1'b1;
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic sample_and_check();
    int                     pre_size [`CCU_NUM_PORTS];
    logic [`CCU_TAG_W-1:0]  tag;
    logic [3:0]             mem_op;
    logic                   exp_err;
    logic [`CCU_DATA_W-1:0] exp_data;
    logic [`CCU_PORT_W-1:0] rsp_port;
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      pre_size[p] = cm_model[p].size();
      assert (cm_valid[p] == pulse_due[p])
        else report_mismatch($sformatf("cm_valid port %0d", p), 64'(pulse_due[p]),
                             64'(cm_valid[p]));
      if (pulse_due[p]) begin
        assert (cm_addr[p] == pulse_addr[p])
          else report_mismatch($sformatf("cm_addr port %0d", p), 64'(pulse_addr[p]),
                               64'(cm_addr[p]));
      end
      pulse_due[p] = 1'b0;
      if (ack[p] && pre_size[p] != 0) begin
        pulse_due[p]  = 1'b1;
        pulse_addr[p] = cm_model[p].pop_front();
      end
    end
    if (mem_req_valid && mem_req_ready) begin
      tag    = mem_req.tag;
      mem_op = mem_req.op;
      assert (rec_busy[tag] && rec_accepted[tag] && !rec_at_mem[tag])
        else report_error($sformatf("memory request for tag %0d not awaiting memory", tag));
      assert (rec_class[tag] != cls_illegal)
        else report_error($sformatf("illegal request with tag %0d reached memory", tag));
      assert (mem_req.write == rec_write[tag])
        else report_mismatch("mem write flag", 64'(rec_write[tag]), 64'(mem_req.write));
      assert (mem_req.addr == rec_addr[tag])
        else report_mismatch("mem addr", 64'(rec_addr[tag]), 64'(mem_req.addr));
      assert (mem_op == rec_op[tag])
        else report_mismatch("mem op", 64'(rec_op[tag]), 64'(mem_op));
      assert (mem_req.wdata == rec_wdata[tag])
        else report_mismatch("mem wdata", 64'(rec_wdata[tag]), 64'(mem_req.wdata));
      rec_at_mem[tag] = 1'b1;
      mem_addr[tag]   = mem_req.addr;
      mem_write[tag]  = mem_req.write;
      mem_pend.push_back(tag);
    end
    if (mem_resp_valid && mem_resp_ready) begin
      // Delivered on the port and id held in its tag
      rsp_port = mem_resp.tag[`CCU_TAG_W-1 -: `CCU_PORT_W];
      assert (resp_valid[rsp_port] && resp_ready[rsp_port])
        else report_error($sformatf("memory response for tag %0d not delivered to port %0d",
                                    mem_resp.tag, rsp_port));
      assert (resp[rsp_port].id == mem_resp.tag[`CCU_ID_W-1:0])
        else report_mismatch("resp id", 64'(mem_resp.tag[`CCU_ID_W-1:0]),
                             64'(resp[rsp_port].id));
      mem_resp_done = 1'b1;
    end
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      if (resp_valid[p] && resp_ready[p]) begin
        tag = {`CCU_PORT_W'(p), resp[p].id};
        assert (rec_busy[tag] && rec_accepted[tag])
          else report_error($sformatf("response on port %0d for id %0d not outstanding",
                                      p, resp[p].id));
        if (rec_class[tag] == cls_illegal) begin
          exp_err  = 1'b1;
          exp_data = '0;
        end else begin
          assert (rec_at_mem[tag])
            else report_error($sformatf("response for tag %0d before memory request", tag));
          exp_err  = 1'b0;
          exp_data = rec_write[tag] ? '0 : (rec_addr[tag] ^ 32'h5a5a5a5a);
        end
        assert (resp[p].err == exp_err)
          else report_mismatch("resp err flag", 64'(exp_err), 64'(resp[p].err));
        assert (resp[p].rdata == exp_data)
          else report_mismatch("resp rdata", 64'(exp_data), 64'(resp[p].rdata));
        if (rec_class[tag] == cls_snoop) begin
          assert (pre_size[p] < `CCU_ACK_DEPTH)
            else report_error($sformatf("snooping response on port %0d with ack queue full", p));
          cm_model[p].push_back(rec_addr[tag][`CCU_CM_BASE +: `CCU_CM_W]);
        end
        rec_busy[tag]     = 1'b0;
        rec_accepted[tag] = 1'b0;
        rec_at_mem[tag]   = 1'b0;
        done_count++;
      end
      if (req_valid[p] && req_ready[p]) begin
        rec_accepted[req_tag[p]] = 1'b1;
        req_taken[p]             = 1'b1;
      end
    end
  endtask

  function automatic logic run_complete();
    logic idle;
    idle = (done_count == num_txn) && (mem_pend.size() == 0) && !mem_resp_valid;
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      idle = idle && (cm_model[p].size() == 0) && !pulse_due[p];
    end
    return idle;
  endfunction

  initial begin
    lfsr_state     = 32'hfc61f8c7;
    clk            = 1'b0;
    reset          = 1'b1;
    req_valid      = '0;
    req            = '0;
    resp_ready     = '0;
    ack            = '0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    mem_resp_done  = 1'b0;
    issued         = 0;
    done_count     = 0;
    for (int t = 0; t < num_tags; t++) begin
      rec_busy[t]     = 1'b0;
      rec_accepted[t] = 1'b0;
      rec_at_mem[t]   = 1'b0;
    end
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      req_taken[p]  = 1'b0;
      pulse_due[p]  = 1'b0;
      pulse_addr[p] = '0;
      req_tag[p]    = '0;
    end
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      if (c == 3) begin
        #2;
        reset = 1'b0;
      end
      @(negedge clk);
      check_idle_outputs("outputs in reset");
    end
    @(posedge clk);
    @(negedge clk);
    check_idle_outputs("outputs after reset");

    finished = 1'b0;
    cycle    = 0;
    while (!finished && cycle < max_cycles) begin
      @(posedge clk);
      #2;
      drive_inputs();
      @(negedge clk);
      sample_and_check();
      finished = run_complete();
      cycle++;
    end
    if (finished) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Timeout after %0d cycles, %0d of %0d transactions done",
               cycle, done_count, num_txn);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
